/* ppu_defines.svh */
/*
 * PPU background layer width macros
 * Beam, playfield, bus and pixel widths shared across the design
 */

`ifndef PPU_DEFINES_SVH
`define PPU_DEFINES_SVH

// Beam coordinate from the display timing
`define PPU_W_SCREEN 9

// Scrolled coordinate, covers the largest playfield
`define PPU_W_PLAYFIELD 10

// System bus
`define PPU_W_ADDR 32
`define PPU_W_DATA 32

// Pixel leaving the layer, without the alpha bit
`define PPU_W_OUT 15

// Tilemap entry
`define PPU_W_TILENUM 8

`endif

/* ppu_pkg.sv */
/*
 * PPU background layer types
 * Vector typedefs for meaningful widths and the pixel depth encoding
 */

`default_nettype none

`include "ppu_defines.svh"

package ppu_pkg;

	typedef logic [`PPU_W_SCREEN-1:0]       screen_coord_t;
	typedef logic [`PPU_W_PLAYFIELD-1:0]    pf_coord_t;
	// log2(playfield size) - 4
	typedef logic [2:0]                     log_size_t;
	typedef logic [`PPU_W_ADDR-1:0]         addr_t;
	typedef logic [`PPU_W_DATA-1:0]         data_t;
	// Raw pixel, widest depth plus alpha
	typedef logic [`PPU_W_OUT:0]            pix_t;
	typedef logic [`PPU_W_OUT-1:0]          outpix_t;
	typedef logic [`PPU_W_TILENUM-1:0]      tilenum_t;
	// Bit position inside one bus word
	typedef logic [$clog2(`PPU_W_DATA)-1:0] shift_t;
	typedef logic [3:0]                     pal_off_t;

	// Code is log2 of the pixel width in bits
	typedef enum logic [2:0] {
		PIX_1BPP  = 3'd0,
		PIX_2BPP  = 3'd1,
		PIX_4BPP  = 3'd2,
		PIX_8BPP  = 3'd3,
		PIX_16BPP = 3'd4
	} pixel_mode_t;

endpackage

`default_nettype wire

/* ppu_pix_if.sv */
/*
 * Unpacked pixel stream
 * Carries one pixel with its alpha flag under a vld/rdy handshake
 */

`timescale 1ns/100ps
`default_nettype none

interface ppu_pix_if;

	// Pixel word, palette index or direct colour
	ppu_pkg::pix_t data;
	logic          alpha;
	// Pixel moves when both are high
	logic          vld;
	logic          rdy;

	// Streamer side
	modport source (
		output data,
		output alpha,
		output vld,
		input  rdy
	);

	// Control side
	modport sink (
		input  data,
		input  alpha,
		input  vld,
		output rdy
	);

endinterface

`default_nettype wire

/* ppu_bg_addr_gen.sv */
/*
 * Background address generator
 * Wraps the scrolled beam position and forms tilemap and tileset addresses
 */

`timescale 1ns/100ps
`default_nettype none

`include "ppu_defines.svh"

module ppu_bg_addr_gen (
	input  ppu_pkg::screen_coord_t beam_x,
	input  ppu_pkg::screen_coord_t beam_y,
	input  ppu_pkg::pf_coord_t     cfg_scroll_x,
	input  ppu_pkg::pf_coord_t     cfg_scroll_y,
	input  ppu_pkg::log_size_t     cfg_log_w,
	input  ppu_pkg::log_size_t     cfg_log_h,
	input  ppu_pkg::addr_t         cfg_tilemap_base,
	input  ppu_pkg::addr_t         cfg_tileset_base,
	input  logic                   cfg_tile_size,
	input  ppu_pkg::pixel_mode_t   cfg_pixel_mode,
	input  ppu_pkg::tilenum_t      tile,
	output ppu_pkg::pf_coord_t     u,
	output ppu_pkg::addr_t         tile_addr,
	output ppu_pkg::addr_t         pixel_addr,
	output ppu_pkg::shift_t        seek
);

	// ----------------------------------------------------------
	// Playfield coordinates

	ppu_pkg::pf_coord_t w_mask;
	ppu_pkg::pf_coord_t h_mask;
	ppu_pkg::pf_coord_t v;

	// Size is 16 << log, wraps to zero for the full 1024 field
	assign w_mask = (ppu_pkg::pf_coord_t'(16) << cfg_log_w) - ppu_pkg::pf_coord_t'(1);
	assign h_mask = (ppu_pkg::pf_coord_t'(16) << cfg_log_h) - ppu_pkg::pf_coord_t'(1);

	assign u = (ppu_pkg::pf_coord_t'(beam_x) + cfg_scroll_x) & w_mask;
	assign v = (ppu_pkg::pf_coord_t'(beam_y) + cfg_scroll_y) & h_mask;

	// ----------------------------------------------------------
	// Tilemap lookup

	logic [2:0]         tile_log;
	logic [3:0]         log_w_tiles;
	ppu_pkg::pf_coord_t col;
	ppu_pkg::pf_coord_t row;
	ppu_pkg::addr_t     tile_idx;

	// 8 or 16 pixel tiles
	assign tile_log = cfg_tile_size ? 3'd4 : 3'd3;
	// Playfield width in tiles, one more doubling for small tiles
	assign log_w_tiles = {1'b0, cfg_log_w} + {3'b000, !cfg_tile_size};

	assign col = u >> tile_log;
	assign row = v >> tile_log;

	assign tile_idx = (ppu_pkg::addr_t'(row) << log_w_tiles) + ppu_pkg::addr_t'(col);
	assign tile_addr = cfg_tilemap_base | tile_idx;

	// ----------------------------------------------------------
	// Tileset lookup

	logic [2:0]     pix_log;
	ppu_pkg::addr_t pix_idx;
	ppu_pkg::addr_t bit_pos;

	assign pix_log = cfg_pixel_mode;

	// Pixel number within the tileset, tile major then row then column
	assign pix_idx = cfg_tile_size ?
		ppu_pkg::addr_t'({tile, v[3:0], u[3:0]}) :
		ppu_pkg::addr_t'({tile, v[2:0], u[2:0]});

	assign bit_pos = pix_idx << pix_log;

	// Byte address, aligned down to a bus word
	assign pixel_addr = (cfg_tileset_base | (bit_pos >> 3)) &
		~ppu_pkg::addr_t'((`PPU_W_DATA / 8) - 1);

	// Where the pixel sits in that word
	assign seek = ppu_pkg::shift_t'(bit_pos);

endmodule

`default_nettype wire

/* ppu_pixel_streamer.sv */
/*
 * Pixel streamer
 * Holds one fetched bus word and shifts pixels out at the configured depth
 */

`timescale 1ns/100ps
`default_nettype none

`include "ppu_defines.svh"

module ppu_pixel_streamer (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 flush,
	input  ppu_pkg::shift_t      seek,
	input  ppu_pkg::pixel_mode_t pixel_mode,
	input  ppu_pkg::pal_off_t    palette_offset,
	output logic                 load_req,
	input  logic                 load_ack,
	input  ppu_pkg::data_t       load_data,
	ppu_pix_if.source            pix
);

	// Enough to count a full word of bits
	localparam int W_CNT = $clog2(`PPU_W_DATA) + 1;

	ppu_pkg::data_t   shift_q;
	logic [W_CNT-1:0] bits_left;
	logic [W_CNT-1:0] pix_bits;
	logic             realign;
	logic             pix_take;

	assign pix_bits = W_CNT'(1) << pixel_mode;
	assign pix_take = pix.vld && pix.rdy;

	// Ask for data only once the word is used up
	assign load_req = bits_left == '0;
	assign pix.vld = bits_left != '0;

	// ----------------------------------------------------------
	// Word and bit count

	// Count and realign flag
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bits_left <= '0;
			realign <= 1'b1;
		end else if (flush) begin
			bits_left <= '0;
			realign <= 1'b1;
		end else if (load_ack) begin
			// First word after a flush starts at the seek position
			bits_left <= realign ? W_CNT'(`PPU_W_DATA) - W_CNT'(seek) : W_CNT'(`PPU_W_DATA);
			realign <= 1'b0;
		end else if (pix_take) begin
			bits_left <= bits_left - pix_bits;
		end
	end

	// Shift register contents
	always_ff @(posedge clk) begin
		if (load_ack && !flush) begin
			shift_q <= realign ? load_data >> seek : load_data;
		end else if (pix_take) begin
			shift_q <= shift_q >> pix_bits;
		end
	end

	// ----------------------------------------------------------
	// Pixel formatting

	logic [7:0] idx_mask;
	logic [7:0] idx;

	always_comb begin
		case (pixel_mode)
			ppu_pkg::PIX_1BPP: idx_mask = 8'h01;
			ppu_pkg::PIX_2BPP: idx_mask = 8'h03;
			ppu_pkg::PIX_4BPP: idx_mask = 8'h0f;
			default:           idx_mask = 8'hff;
		endcase
	end

	assign idx = shift_q[7:0] & idx_mask;

	always_comb begin
		if (pixel_mode == ppu_pkg::PIX_16BPP) begin
			// Direct colour, top bit is alpha
			pix.data = shift_q[15:0];
			pix.alpha = shift_q[15];
		end else if (pixel_mode == ppu_pkg::PIX_8BPP) begin
			pix.data = {8'h00, idx};
			pix.alpha = |idx;
		end else begin
			// Small depths pick a 16 entry bank of the palette
			pix.data = {8'h00, palette_offset, idx[3:0]};
			pix.alpha = |idx;
		end
	end

endmodule

`default_nettype wire

/* ppu_bg_ctrl.sv */
/*
 * Background control
 * Tile register, tile pixel count, bus arbitration and output gating
 */

`timescale 1ns/100ps
`default_nettype none

`include "ppu_defines.svh"

module ppu_bg_ctrl (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               en,
	input  logic               flush,
	input  ppu_pkg::pf_coord_t u,
	input  logic               cfg_tile_size,
	input  logic               cfg_transparency,
	input  ppu_pkg::addr_t     tile_addr,
	input  ppu_pkg::addr_t     pixel_addr,
	input  logic               load_req,
	output ppu_pkg::tilenum_t  tile,
	output logic               bus_vld,
	output ppu_pkg::addr_t     bus_addr,
	output logic [1:0]         bus_size,
	input  logic               bus_rdy,
	input  ppu_pkg::data_t     bus_data,
	output logic               load_ack,
	output ppu_pkg::data_t     load_data,
	output logic               streamer_flush,
	ppu_pix_if.sink            pix,
	input  logic               out_rdy,
	output logic               out_vld,
	output logic               out_alpha,
	output ppu_pkg::outpix_t   out_pixdata
);

	logic       tile_empty;
	logic       stale;
	logic       tile_load;
	logic       out_take;
	logic [3:0] tile_pixctr;
	logic [3:0] tile_last;

	// ----------------------------------------------------------
	// Bus arbitration

	// Tile fetch wins, pixel fetch only with a tile in hand
	assign bus_addr = tile_empty ? tile_addr : pixel_addr;
	assign bus_size = tile_empty ? 2'd0 : 2'($clog2(`PPU_W_DATA) - 3);
	// Streamer wants a word whenever it has nothing to show
	assign bus_vld = ((tile_empty || load_req) && en) || stale;

	assign tile_load = bus_vld && bus_rdy && !stale && tile_empty;
	assign load_ack = bus_vld && bus_rdy && !stale && !tile_empty;
	assign load_data = bus_data;

	// Read in flight across a flush, its data is dropped
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stale <= 1'b0;
		end else begin
			stale <= (stale || (bus_vld && flush)) && !bus_rdy;
		end
	end

	// ----------------------------------------------------------
	// Tile register and pixel count

	assign tile_last = {cfg_tile_size, 3'b111};
	assign out_take = pix.vld && pix.rdy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tile_empty <= 1'b1;
			tile_pixctr <= '0;
		end else if (flush) begin
			tile_empty <= 1'b1;
			// Line may start mid tile
			tile_pixctr <= u[3:0] & tile_last;
		end else if (tile_empty) begin
			if (tile_load) begin
				tile_empty <= 1'b0;
			end
		end else if (out_take) begin
			tile_pixctr <= tile_pixctr + 4'd1;
			if (tile_pixctr == tile_last) begin
				tile_empty <= 1'b1;
				tile_pixctr <= '0;
			end
		end
	end

	// Tilemap byte
	always_ff @(posedge clk) begin
		if (tile_load && !flush) begin
			tile <= bus_data[`PPU_W_TILENUM-1:0];
		end
	end

	// ----------------------------------------------------------
	// Output

	assign streamer_flush = flush || tile_empty;
	assign pix.rdy = en && out_rdy && !flush && !tile_empty;

	// Disabled layer shows a steady transparent pixel
	assign out_vld = !en || (pix.vld && !flush && !tile_empty);
	assign out_alpha = en && (!cfg_transparency || pix.alpha);
	assign out_pixdata = pix.data[`PPU_W_OUT-1:0];

endmodule

`default_nettype wire

/* ppu_bg_top.sv */
/*
 * PPU background layer
 * Tilemap and tileset fetch feeding an unpacked pixel stream
 */

`timescale 1ns/100ps
`default_nettype none

module ppu_bg_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   en,
	input  logic                   flush,
	input  ppu_pkg::screen_coord_t beam_x,
	input  ppu_pkg::screen_coord_t beam_y,
	output logic                   bus_vld,
	output ppu_pkg::addr_t         bus_addr,
	output logic [1:0]             bus_size,
	input  logic                   bus_rdy,
	input  ppu_pkg::data_t         bus_data,
	input  ppu_pkg::pf_coord_t     cfg_scroll_x,
	input  ppu_pkg::pf_coord_t     cfg_scroll_y,
	input  ppu_pkg::log_size_t     cfg_log_w,
	input  ppu_pkg::log_size_t     cfg_log_h,
	input  ppu_pkg::addr_t         cfg_tileset_base,
	input  ppu_pkg::addr_t         cfg_tilemap_base,
	input  logic                   cfg_tile_size,
	input  ppu_pkg::pixel_mode_t   cfg_pixel_mode,
	input  logic                   cfg_transparency,
	input  ppu_pkg::pal_off_t      cfg_palette_offset,
	output logic                   out_vld,
	input  logic                   out_rdy,
	output logic                   out_alpha,
	output ppu_pkg::outpix_t       out_pixdata
);

	ppu_pkg::pf_coord_t u;
	ppu_pkg::addr_t     tile_addr;
	ppu_pkg::addr_t     pixel_addr;
	ppu_pkg::shift_t    seek;
	ppu_pkg::tilenum_t  tile;
	ppu_pkg::data_t     load_data;
	logic               load_req;
	logic               load_ack;
	logic               streamer_flush;

	// Streamer to control
	ppu_pix_if pix_bus ();

	ppu_bg_addr_gen u_addr_gen (
		.beam_x           (beam_x),
		.beam_y           (beam_y),
		.cfg_scroll_x     (cfg_scroll_x),
		.cfg_scroll_y     (cfg_scroll_y),
		.cfg_log_w        (cfg_log_w),
		.cfg_log_h        (cfg_log_h),
		.cfg_tilemap_base (cfg_tilemap_base),
		.cfg_tileset_base (cfg_tileset_base),
		.cfg_tile_size    (cfg_tile_size),
		.cfg_pixel_mode   (cfg_pixel_mode),
		.tile             (tile),
		.u                (u),
		.tile_addr        (tile_addr),
		.pixel_addr       (pixel_addr),
		.seek             (seek)
	);

	ppu_pixel_streamer u_streamer (
		.clk            (clk),
		.rst_n          (rst_n),
		.flush          (streamer_flush),
		.seek           (seek),
		.pixel_mode     (cfg_pixel_mode),
		.palette_offset (cfg_palette_offset),
		.load_req       (load_req),
		.load_ack       (load_ack),
		.load_data      (load_data),
		.pix            (pix_bus)
	);

	ppu_bg_ctrl u_ctrl (
		.clk              (clk),
		.rst_n            (rst_n),
		.en               (en),
		.flush            (flush),
		.u                (u),
		.cfg_tile_size    (cfg_tile_size),
		.cfg_transparency (cfg_transparency),
		.tile_addr        (tile_addr),
		.pixel_addr       (pixel_addr),
		.load_req         (load_req),
		.tile             (tile),
		.bus_vld          (bus_vld),
		.bus_addr         (bus_addr),
		.bus_size         (bus_size),
		.bus_rdy          (bus_rdy),
		.bus_data         (bus_data),
		.load_ack         (load_ack),
		.load_data        (load_data),
		.streamer_flush   (streamer_flush),
		.pix              (pix_bus),
		.out_rdy          (out_rdy),
		.out_vld          (out_vld),
		.out_alpha        (out_alpha),
		.out_pixdata      (out_pixdata)
	);

endmodule

`default_nettype wire

/* tb_ppu_bg.sv */
/*
 * Testbench for the PPU background layer
 * Byte/word memory model, reference pixel model and line-by-line checks
 */

`timescale 1ns/100ps
`default_nettype none

module tb_ppu_bg;

	localparam int N_LINES     = 16;
	localparam int LINE_PIX    = 48;
	localparam int CYCLE_LIMIT = N_LINES * LINE_PIX * 20;
	localparam int SEED        = 32'habff;

	logic                   clk;
	logic                   rst_n;
	logic                   en;
	logic                   flush;
	ppu_pkg::screen_coord_t beam_x;
	ppu_pkg::screen_coord_t beam_y;
	logic                   bus_vld;
	ppu_pkg::addr_t         bus_addr;
	logic [1:0]             bus_size;
	logic                   bus_rdy = 1'b0;
	ppu_pkg::data_t         bus_data;
	ppu_pkg::pf_coord_t     cfg_scroll_x;
	ppu_pkg::pf_coord_t     cfg_scroll_y;
	ppu_pkg::log_size_t     cfg_log_w;
	ppu_pkg::log_size_t     cfg_log_h;
	ppu_pkg::addr_t         cfg_tileset_base;
	ppu_pkg::addr_t         cfg_tilemap_base;
	logic                   cfg_tile_size;
	ppu_pkg::pixel_mode_t   cfg_pixel_mode;
	logic                   cfg_transparency;
	ppu_pkg::pal_off_t      cfg_palette_offset;
	logic                   out_vld;
	logic                   out_rdy;
	logic                   out_alpha;
	ppu_pkg::outpix_t       out_pixdata;

	// Holds the memory off the bus to leave a read pending
	logic bus_hold;
	// Pixel checks only run inside a line
	logic check_on;
	int   bus_seed = SEED;
	int   stall_seed = SEED;
	int   cycles = 0;

	ppu_bg_top i_dut (
		.clk                (clk),
		.rst_n              (rst_n),
		.en                 (en),
		.flush              (flush),
		.beam_x             (beam_x),
		.beam_y             (beam_y),
		.bus_vld            (bus_vld),
		.bus_addr           (bus_addr),
		.bus_size           (bus_size),
		.bus_rdy            (bus_rdy),
		.bus_data           (bus_data),
		.cfg_scroll_x       (cfg_scroll_x),
		.cfg_scroll_y       (cfg_scroll_y),
		.cfg_log_w          (cfg_log_w),
		.cfg_log_h          (cfg_log_h),
		.cfg_tileset_base   (cfg_tileset_base),
		.cfg_tilemap_base   (cfg_tilemap_base),
		.cfg_tile_size      (cfg_tile_size),
		.cfg_pixel_mode     (cfg_pixel_mode),
		.cfg_transparency   (cfg_transparency),
		.cfg_palette_offset (cfg_palette_offset),
		.out_vld            (out_vld),
		.out_rdy            (out_rdy),
		.out_alpha          (out_alpha),
		.out_pixdata        (out_pixdata)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ----------------------------------------------------------
	// Memory model

	// Word contents, a hash over every address bit
	function automatic ppu_pkg::data_t mem_word(input ppu_pkg::addr_t addr);
		ppu_pkg::addr_t a;
		a = addr & ~32'h3;
		return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h3c5aa5c3;
	endfunction

	// Byte lane picked by the low address bits
	function automatic ppu_pkg::tilenum_t mem_byte(input ppu_pkg::addr_t addr);
		ppu_pkg::data_t w;
		w = mem_word(addr);
		return ppu_pkg::tilenum_t'(w >> {addr[1:0], 3'b000});
	endfunction

	// A request that has to wait is captured, the answer is for what was asked
	logic           req_open = 1'b0;
	ppu_pkg::addr_t req_addr;
	logic [1:0]     req_size;
	ppu_pkg::addr_t rd_addr;
	logic [1:0]     rd_size;

	always @(posedge clk) begin
		if (!bus_vld || bus_rdy) begin
			req_open <= 1'b0;
		end else if (!req_open) begin
			req_open <= 1'b1;
			req_addr <= bus_addr;
			req_size <= bus_size;
		end
	end

	assign rd_addr = req_open ? req_addr : bus_addr;
	assign rd_size = req_open ? req_size : bus_size;

	assign bus_data = (rd_size == 2'd0) ? ppu_pkg::data_t'(mem_byte(rd_addr)) :
		mem_word(rd_addr);

	// Ready about three cycles in four
	always @(posedge clk) begin
		bus_rdy <= !bus_hold && (($random(bus_seed) & 3) != 0);
	end

	// ----------------------------------------------------------
	// Reference model and checks

	// Expected {alpha, pixel} for beam position x, y
	function automatic logic [15:0] ref_pixel(
		input ppu_pkg::pixel_mode_t mode,
		input logic                 tile16,
		input ppu_pkg::log_size_t   lw,
		input ppu_pkg::log_size_t   lh,
		input ppu_pkg::pf_coord_t   sx,
		input ppu_pkg::pf_coord_t   sy,
		input ppu_pkg::addr_t       map_base,
		input ppu_pkg::addr_t       set_base,
		input ppu_pkg::pal_off_t    pal,
		input logic                 transp,
		input int                   x,
		input int                   y
	);
		int                size_w;
		int                size_h;
		int                tsz;
		int                u;
		int                v;
		int                bpp;
		int                pidx;
		int                bitpos;
		ppu_pkg::tilenum_t tnum;
		ppu_pkg::data_t    word;
		ppu_pkg::data_t    field;
		ppu_pkg::outpix_t  pix;
		logic              alpha;
		size_w = 16 << int'(lw);
		size_h = 16 << int'(lh);
		// Playfield wraps at its power of two size
		u = (x + int'(sx)) & (size_w - 1);
		v = (y + int'(sy)) & (size_h - 1);
		tsz = tile16 ? 16 : 8;
		tnum = mem_byte(map_base | ppu_pkg::addr_t'((v / tsz) * (size_w / tsz) + u / tsz));
		bpp = 1 << int'(mode);
		// Tiles stored whole, rows of pixels inside
		pidx = (int'(tnum) * tsz + (v % tsz)) * tsz + (u % tsz);
		bitpos = pidx * bpp;
		word = mem_word(set_base | ppu_pkg::addr_t'(bitpos / 8));
		field = (word >> (bitpos % 32)) & ((32'd1 << bpp) - 32'd1);
		if (mode == ppu_pkg::PIX_16BPP) begin
			pix = field[14:0];
			alpha = field[15];
		end else if (mode == ppu_pkg::PIX_8BPP) begin
			pix = {7'd0, field[7:0]};
			alpha = |field;
		end else begin
			pix = {7'd0, pal, field[3:0]};
			alpha = |field;
		end
		if (!transp) begin
			alpha = 1'b1;
		end
		return {alpha, pix};
	endfunction

	task automatic stop_fail(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_pix(input ppu_pkg::outpix_t got, input ppu_pkg::outpix_t exp,
		input int x, input int y);
		if (got !== exp) begin
			stop_fail($sformatf("ERR %0t: pixel (%0d,%0d) is %h, expected %h",
				$time, x, y, got, exp));
		end
	endtask

	task automatic check_alpha(input logic got, input logic exp, input string where);
		if (got !== exp) begin
			stop_fail($sformatf("ERR %0t: alpha %s is %b, expected %b",
				$time, where, got, exp));
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			stop_fail($sformatf("ERR %0t: %s is %b, expected %b", $time, name, got, exp));
		end
	endtask

	// Compares every accepted pixel of a line
	always @(posedge clk) begin
		logic [15:0] exp;
		if (rst_n && check_on && en && out_vld && out_rdy) begin
			exp = ref_pixel(cfg_pixel_mode, cfg_tile_size, cfg_log_w, cfg_log_h,
				cfg_scroll_x, cfg_scroll_y, cfg_tilemap_base, cfg_tileset_base,
				cfg_palette_offset, cfg_transparency, int'(beam_x), int'(beam_y));
			check_pix(out_pixdata, exp[14:0], int'(beam_x), int'(beam_y));
			check_alpha(out_alpha, exp[15], $sformatf("at x %0d", beam_x));
		end
	end

	// Hang guard
	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			stop_fail($sformatf("Timeout: no progress after %0d clock cycles", cycles));
		end
	end

	// ----------------------------------------------------------
	// Stimulus

	task automatic set_cfg(input ppu_pkg::pixel_mode_t mode, input logic tile16,
		input ppu_pkg::log_size_t lw, input ppu_pkg::log_size_t lh,
		input ppu_pkg::pf_coord_t sx, input ppu_pkg::pf_coord_t sy,
		input ppu_pkg::pal_off_t pal, input logic transp);
		@(posedge clk);
		cfg_pixel_mode <= mode;
		cfg_tile_size <= tile16;
		cfg_log_w <= lw;
		cfg_log_h <= lh;
		cfg_scroll_x <= sx;
		cfg_scroll_y <= sy;
		cfg_palette_offset <= pal;
		cfg_transparency <= transp;
	endtask

	// Flush, then take one line of pixels, optionally with output stalls
	task automatic run_line(input int y, input logic stalls);
		int n;
		@(posedge clk);
		flush <= 1'b1;
		beam_x <= '0;
		beam_y <= ppu_pkg::screen_coord_t'(y);
		bus_hold <= 1'b0;
		out_rdy <= 1'b0;
		@(posedge clk);
		flush <= 1'b0;
		check_on <= 1'b1;
		out_rdy <= stalls ? 1'($random(stall_seed)) : 1'b1;
		n = 0;
		while (n < LINE_PIX) begin
			@(posedge clk);
			// Beam follows every accepted pixel
			if (out_vld && out_rdy) begin
				n++;
				beam_x <= beam_x + 9'd1;
			end
			if (n < LINE_PIX) begin
				out_rdy <= stalls ? 1'($random(stall_seed)) : 1'b1;
			end else begin
				out_rdy <= 1'b0;
			end
		end
		check_on <= 1'b0;
	endtask

	// Layer off over a fresh line, steady transparent output and no new fetch
	task automatic run_disabled(input int n);
		@(posedge clk);
		en <= 1'b0;
		flush <= 1'b1;
		beam_x <= '0;
		out_rdy <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		repeat (n) begin
			@(posedge clk);
			check_flag(out_vld, 1'b1, "out_vld while disabled");
			check_alpha(out_alpha, 1'b0, "while disabled");
			// Tile register is empty, an enabled layer would fetch here
			check_flag(bus_vld, 1'b0, "bus_vld while disabled");
		end
		@(posedge clk);
		en <= 1'b1;
		out_rdy <= 1'b0;
	endtask

	// Line start with the bus stalled, then a second flush over the pending read
	task automatic flush_over_pending(input int y0, input int y1);
		@(posedge clk);
		bus_hold <= 1'b1;
		flush <= 1'b1;
		beam_x <= '0;
		beam_y <= ppu_pkg::screen_coord_t'(y0);
		@(posedge clk);
		flush <= 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		if (!bus_vld || bus_rdy) begin
			stop_fail("No bus read was pending before the second flush");
		end
		run_line(y1, 1'b0);
	endtask

	initial begin
		rst_n = 1'b0;
		en = 1'b1;
		flush = 1'b0;
		beam_x = '0;
		beam_y = '0;
		out_rdy = 1'b0;
		bus_hold = 1'b0;
		check_on = 1'b0;
		cfg_scroll_x = '0;
		cfg_scroll_y = '0;
		cfg_log_w = 3'd2;
		cfg_log_h = 3'd2;
		cfg_tileset_base = 32'h0010_0000;
		cfg_tilemap_base = 32'h0002_0000;
		cfg_tile_size = 1'b0;
		cfg_pixel_mode = ppu_pkg::PIX_1BPP;
		cfg_transparency = 1'b0;
		cfg_palette_offset = '0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		// Every depth, small tiles, no scroll
		for (int m = 0; m < 5; m++) begin
			set_cfg(ppu_pkg::pixel_mode_t'(m), 1'b0, 3'd2, 3'd2, 10'd0, 10'd0, 4'd0, 1'b0);
			run_line(3 * m + 1, 1'b0);
		end

		// Large tiles, odd scroll, 32 wide field so the line wraps
		set_cfg(ppu_pkg::PIX_2BPP, 1'b1, 3'd1, 3'd1, 10'd21, 10'd37, 4'd0, 1'b0);
		run_line(2, 1'b0);
		set_cfg(ppu_pkg::PIX_16BPP, 1'b1, 3'd1, 3'd1, 10'd21, 10'd37, 4'd0, 1'b1);
		run_line(9, 1'b0);

		// Palette bank with and without transparency
		set_cfg(ppu_pkg::PIX_4BPP, 1'b0, 3'd2, 3'd2, 10'd3, 10'd0, 4'ha, 1'b1);
		run_line(6, 1'b0);
		set_cfg(ppu_pkg::PIX_2BPP, 1'b0, 3'd2, 3'd2, 10'd3, 10'd0, 4'h5, 1'b0);
		run_line(7, 1'b0);

		run_disabled(20);

		// Output stalls on top of bus stalls
		set_cfg(ppu_pkg::PIX_1BPP, 1'b1, 3'd2, 3'd1, 10'd13, 10'd4, 4'h3, 1'b1);
		run_line(11, 1'b1);
		set_cfg(ppu_pkg::PIX_8BPP, 1'b1, 3'd2, 3'd1, 10'd13, 10'd4, 4'h3, 1'b1);
		run_line(12, 1'b1);

		// Flush while a tile read hangs on the bus, new line in another tile row
		set_cfg(ppu_pkg::PIX_4BPP, 1'b0, 3'd2, 3'd2, 10'd5, 10'd2, 4'h7, 1'b1);
		flush_over_pending(20, 29);

		repeat (4) @(posedge clk);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
ppu_pkg.sv
ppu_pix_if.sv
ppu_bg_addr_gen.sv
ppu_pixel_streamer.sv
ppu_bg_ctrl.sv
ppu_bg_top.sv
tb_ppu_bg.sv

/* Makefile */
# Verilator build and run for the PPU background layer testbench

VERILATOR ?= verilator
TOP       ?= tb_ppu_bg
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

# The run exits nonzero when the testbench fails
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
